//--- hw/roce_proto_pkg.sv
//======================================================================
// RoCE protocol definitions
// Header constants and the first-beat view used by the packet parser
//======================================================================

package roce_proto_pkg;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;
  localparam logic [15:0] ROCE_UDP_PORT  = 16'd4791;

  // Header fields in wire order, first byte on the wire at the MSB
  typedef struct packed {
    // Ethernet
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
    // IPv4, version through ttl kept as one group
    logic [71:0] ip_misc;
    logic [7:0]  ip_proto;
    logic [15:0] ip_csum;
    logic [31:0] ip_src;
    logic [31:0] ip_dst;
    // UDP
    logic [15:0] udp_sport;
    logic [15:0] udp_dport;
    logic [15:0] udp_len;
    logic [15:0] udp_csum;
    // Base transport header
    logic [7:0]  bth_opcode;
    logic [7:0]  bth_flags;
    logic [15:0] bth_pkey;
    logic [7:0]  bth_rsvd;
    logic [23:0] bth_dest_qp;
    logic [7:0]  bth_ack;
    logic [23:0] bth_psn;
    // Rest of the beat
    logic [79:0] pad;
  } hdr_fields_t;

  // One 512-bit beat, forwarded as raw data and decoded as headers
  typedef union packed {
    logic [511:0] raw;
    hdr_fields_t  hdr;
  } first_beat_u;

endpackage

//--- hw/axis_stream_pkg.sv
//======================================================================
// Stream definitions
// Beat and metadata records shared by the receive path blocks
//======================================================================

package axis_stream_pkg;

  localparam int DATA_W  = 512;
  localparam int KEEP_W  = 64;
  localparam int SIZE_W  = 16;
  localparam int COUNT_W = 32;

  // One stream beat with its packet-size user field
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic [SIZE_W-1:0] size;
    logic              last;
  } beat_t;

  // Per-packet record sent alongside the first RoCE beat
  typedef struct packed {
    logic [31:0]       ip_src;
    logic [31:0]       ip_dst;
    logic [15:0]       udp_sport;
    logic [15:0]       udp_dport;
    logic [4:0]        opcode;
    logic [23:0]       psn;
    logic [SIZE_W-1:0] pktlen;
    logic              is_rdma;
  } roce_meta_t;

endpackage

//--- hw/rx_fifo.sv
//======================================================================
// Receive buffer
// Synchronous first-word-fall-through ring buffer for MAC beats
//======================================================================

module rx_fifo
  import axis_stream_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input  logic  axis_aclk,
  input  logic  axis_rstn,
  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,
  output beat_t head,
  output logic  head_valid,
  input  logic  head_pop
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  beat_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready   = (count != CNT_W'(FIFO_DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = head_pop && head_valid;

  // Storage
  always_ff @(posedge axis_aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge axis_aclk)
  begin
    if (!axis_rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !push)
      begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hw/header_parser.sv
//======================================================================
// Header parser
// Decodes the first beat of each packet into a RoCE flag and the
// metadata record for the RDMA engine
//======================================================================

module header_parser
  import axis_stream_pkg::*;
  import roce_proto_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       axis_rstn,
  input  beat_t      head,
  input  logic       head_valid,
  input  logic       head_pop,
  output logic       is_roce,
  output roce_meta_t meta
);

  logic        first_beat;
  first_beat_u fb;

  // Next popped beat starts a packet after reset or after a last beat
  always_ff @(posedge axis_aclk)
  begin
    if (!axis_rstn)
    begin
      first_beat <= 1'b1;
    end
    else if (head_pop)
    begin
      first_beat <= head.last;
    end
  end

  assign fb.raw = head.data;

  //====================================================================
  // Classification
  //====================================================================

  // IPv4, carrying UDP, to the RoCEv2 port
  assign is_roce = head_valid && first_beat &&
                   (fb.hdr.ethertype == ETHERTYPE_IPV4) &&
                   (fb.hdr.ip_proto  == IP_PROTO_UDP) &&
                   (fb.hdr.udp_dport == ROCE_UDP_PORT);

  //====================================================================
  // Metadata fields
  //====================================================================

  always_comb
  begin
    meta.ip_src    = fb.hdr.ip_src;
    meta.ip_dst    = fb.hdr.ip_dst;
    meta.udp_sport = fb.hdr.udp_sport;
    meta.udp_dport = fb.hdr.udp_dport;
    // Low five opcode bits select the operation within a transport class
    meta.opcode    = fb.hdr.bth_opcode[4:0];
    meta.psn       = fb.hdr.bth_psn;
    meta.pktlen    = head.size;
    meta.is_rdma   = is_roce;
  end

endmodule

//--- hw/pkt_steer.sv
//======================================================================
// Packet steering
// Routes whole packets to the RoCE or host stream through one output
// register each, and issues the metadata with the first RoCE beat
//======================================================================

module pkt_steer
  import axis_stream_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       axis_rstn,
  input  beat_t      head,
  input  logic       head_valid,
  output logic       head_pop,
  input  logic       is_roce,
  input  roce_meta_t meta,
  output beat_t      roce_beat,
  output logic       roce_valid,
  input  logic       roce_ready,
  output beat_t      other_beat,
  output logic       other_valid,
  input  logic       other_ready,
  output roce_meta_t meta_out,
  output logic       meta_valid
);

  logic route_roce;
  logic first_beat;
  logic sel_roce;
  logic roce_space;
  logic other_space;
  logic load_roce;
  logic load_other;

  // First beat decides, the rest of the packet follows the latched route
  assign sel_roce = first_beat ? is_roce : route_roce;

  // Register can take a beat when empty or emptied this cycle
  assign roce_space  = !roce_valid || roce_ready;
  assign other_space = !other_valid || other_ready;

  assign head_pop   = head_valid && (sel_roce ? roce_space : other_space);
  assign load_roce  = head_pop && sel_roce;
  assign load_other = head_pop && !sel_roce;

  //====================================================================
  // Packet tracking
  //====================================================================

  always_ff @(posedge axis_aclk)
  begin
    if (!axis_rstn)
    begin
      route_roce <= 1'b0;
      first_beat <= 1'b1;
    end
    else if (head_pop)
    begin
      if (first_beat)
      begin
        route_roce <= is_roce;
      end
      first_beat <= head.last;
    end
  end

  //====================================================================
  // Output registers
  //====================================================================

  always_ff @(posedge axis_aclk)
  begin
    if (!axis_rstn)
    begin
      roce_valid  <= 1'b0;
      other_valid <= 1'b0;
      meta_valid  <= 1'b0;
    end
    else
    begin
      if (roce_space)
      begin
        roce_valid <= load_roce;
        meta_valid <= load_roce && first_beat;
      end
      if (other_space)
      begin
        other_valid <= load_other;
      end
    end
  end

  // Payload only changes on a load, so it holds under back-pressure
  always_ff @(posedge axis_aclk)
  begin
    if (load_roce)
    begin
      roce_beat <= head;
    end
    if (load_roce && first_beat)
    begin
      meta_out <= meta;
    end
    if (load_other)
    begin
      other_beat <= head;
    end
  end

endmodule

//--- hw/pkt_counter.sv
//======================================================================
// Packet counter
// Saturating count of packets completed on one output stream
//======================================================================

module pkt_counter
  import axis_stream_pkg::*;
(
  input  logic               axis_aclk,
  input  logic               axis_rstn,
  input  logic               valid,
  input  logic               ready,
  input  logic               last,
  output logic [COUNT_W-1:0] count
);

  logic pkt_done;

  assign pkt_done = valid && ready && last;

  always_ff @(posedge axis_aclk)
  begin
    if (!axis_rstn)
    begin
      count <= '0;
    end
    else if (pkt_done && (count != '1))
    begin
      // Stops at all ones
      count <= count + 1'b1;
    end
  end

endmodule

//--- hw/roce_rx_top.sv
//======================================================================
// RoCE receive shell
// Buffers the MAC stream, classifies each packet and steers it to the
// RDMA engine or to host DMA, with per-output packet counts
//======================================================================

module roce_rx_top
  import axis_stream_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input  logic               axis_aclk,
  input  logic               axis_rstn,
  input  beat_t              in_beat,
  input  logic               in_valid,
  output logic               in_ready,
  output beat_t              roce_beat,
  output logic               roce_valid,
  input  logic               roce_ready,
  output beat_t              other_beat,
  output logic               other_valid,
  input  logic               other_ready,
  output roce_meta_t         meta_out,
  output logic               meta_valid,
  output logic [COUNT_W-1:0] roce_count,
  output logic [COUNT_W-1:0] other_count
);

  beat_t      head;
  logic       head_valid;
  logic       head_pop;
  logic       is_roce;
  roce_meta_t meta;

  rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rx_fifo (
    .axis_aclk  (axis_aclk),
    .axis_rstn  (axis_rstn),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .head       (head),
    .head_valid (head_valid),
    .head_pop   (head_pop)
  );

  header_parser u_header_parser (
    .axis_aclk  (axis_aclk),
    .axis_rstn  (axis_rstn),
    .head       (head),
    .head_valid (head_valid),
    .head_pop   (head_pop),
    .is_roce    (is_roce),
    .meta       (meta)
  );

  pkt_steer u_pkt_steer (
    .axis_aclk   (axis_aclk),
    .axis_rstn   (axis_rstn),
    .head        (head),
    .head_valid  (head_valid),
    .head_pop    (head_pop),
    .is_roce     (is_roce),
    .meta        (meta),
    .roce_beat   (roce_beat),
    .roce_valid  (roce_valid),
    .roce_ready  (roce_ready),
    .other_beat  (other_beat),
    .other_valid (other_valid),
    .other_ready (other_ready),
    .meta_out    (meta_out),
    .meta_valid  (meta_valid)
  );

  // Completed packets per output
  pkt_counter u_roce_cnt (
    .axis_aclk (axis_aclk),
    .axis_rstn (axis_rstn),
    .valid     (roce_valid),
    .ready     (roce_ready),
    .last      (roce_beat.last),
    .count     (roce_count)
  );

  pkt_counter u_other_cnt (
    .axis_aclk (axis_aclk),
    .axis_rstn (axis_rstn),
    .valid     (other_valid),
    .ready     (other_ready),
    .last      (other_beat.last),
    .count     (other_count)
  );

endmodule

//--- tests/roce_rx_props.sv
//======================================================================
// RoCE receive shell properties
// Output stability under back-pressure, metadata strobe, reset state
//======================================================================

module roce_rx_props
  import axis_stream_pkg::*;
(
  input logic  axis_aclk,
  input logic  axis_rstn,
  input beat_t roce_beat,
  input logic  roce_valid,
  input logic  roce_ready,
  input beat_t other_beat,
  input logic  other_valid,
  input logic  other_ready,
  input logic  meta_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // A stalled beat stays put until it is taken
  a_roce_hold : assert property (@(posedge axis_aclk) disable iff (!axis_rstn)
    (roce_valid && !roce_ready) |=> (roce_valid && $stable(roce_beat)))
    else $error("roce output changed while stalled");

  a_other_hold : assert property (@(posedge axis_aclk) disable iff (!axis_rstn)
    (other_valid && !other_ready) |=> (other_valid && $stable(other_beat)))
    else $error("other output changed while stalled");

  a_meta_with_roce : assert property (@(posedge axis_aclk) disable iff (!axis_rstn)
    meta_valid |-> roce_valid)
    else $error("meta_valid without roce_valid");

  a_reset_idle : assert property (@(posedge axis_aclk)
    !axis_rstn |=> (!roce_valid && !other_valid && !meta_valid))
    else $error("outputs active during reset");

endmodule

bind roce_rx_top roce_rx_props u_props (
  .axis_aclk   (axis_aclk),
  .axis_rstn   (axis_rstn),
  .roce_beat   (roce_beat),
  .roce_valid  (roce_valid),
  .roce_ready  (roce_ready),
  .other_beat  (other_beat),
  .other_valid (other_valid),
  .other_ready (other_ready),
  .meta_valid  (meta_valid)
);

//--- tests/tb_roce_rx.sv
//======================================================================
// RoCE receive shell testbench
// Replays packets from the test data file with random back-pressure
// and checks routes, beats, metadata and packet counts
//======================================================================

module tb_roce_rx
  import axis_stream_pkg::*;
  import roce_proto_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIFO_DEPTH = 8;
  localparam int COLS       = 11;
  localparam int MAX_PKTS   = 64;
  localparam int STALL_PKT  = 8;

  logic               axis_aclk   = 1'b0;
  logic               axis_rstn   = 1'b0;
  beat_t              in_beat     = '0;
  logic               in_valid    = 1'b0;
  logic               in_ready;
  beat_t              roce_beat;
  logic               roce_valid;
  logic               roce_ready  = 1'b0;
  beat_t              other_beat;
  logic               other_valid;
  logic               other_ready = 1'b0;
  roce_meta_t         meta_out;
  logic               meta_valid;
  logic [COUNT_W-1:0] roce_count;
  logic [COUNT_W-1:0] other_count;

  logic [31:0] td [MAX_PKTS*COLS];
  beat_t       exp_roce [$];
  beat_t       exp_other [$];
  roce_meta_t  exp_meta [$];
  int          n_pkts        = 0;
  int          total_beats   = 0;
  int          n_roce_pkts   = 0;
  int          n_other_pkts  = 0;
  int          cycles        = 0;
  int          cycle_limit   = 0;
  int          stall_accepts = 0;
  logic        stall         = 1'b0;
  logic        stall_seen    = 1'b0;
  logic        roce_first    = 1'b1;

  roce_rx_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .axis_aclk   (axis_aclk),
    .axis_rstn   (axis_rstn),
    .in_beat     (in_beat),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .roce_beat   (roce_beat),
    .roce_valid  (roce_valid),
    .roce_ready  (roce_ready),
    .other_beat  (other_beat),
    .other_valid (other_valid),
    .other_ready (other_ready),
    .meta_out    (meta_out),
    .meta_valid  (meta_valid),
    .roce_count  (roce_count),
    .other_count (other_count)
  );

  always #4 axis_aclk = ~axis_aclk;

  task automatic check_equal(input logic [1023:0] got, input logic [1023:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // Run limit scales with the amount of traffic in the data file
  always @(posedge axis_aclk)
  begin
    cycles = cycles + 1;
    if ((cycle_limit != 0) && (cycles >= cycle_limit))
    begin
      $display("Run timed out after %0d cycles with traffic still pending", cycles);
      $display("Something failed");
      $fatal(1);
    end
  end

  //====================================================================
  // Output side: random ready, beat and metadata checks
  //====================================================================

  always @(negedge axis_aclk)
  begin
    roce_ready  = !stall && (($urandom % 4) != 0);
    other_ready = !stall && (($urandom % 4) != 0);
    if (axis_rstn)
    begin
      check_equal(1024'(meta_valid), 1024'(roce_valid && roce_first), "meta_valid");
      // Metadata stays valid for as long as the first RoCE beat waits
      if (meta_valid)
      begin
        check_equal(1024'(exp_meta.size() != 0), 1024'(1), "unexpected metadata");
        check_equal(1024'(meta_out), 1024'(exp_meta[0]), "metadata");
      end
      // Valid and ready now means a transfer on the coming rising edge
      if (roce_valid && roce_ready)
      begin
        check_equal(1024'(exp_roce.size() != 0), 1024'(1), "unexpected roce beat");
        if (roce_first)
        begin
          void'(exp_meta.pop_front());
        end
        check_equal(1024'(roce_beat), 1024'(exp_roce.pop_front()), "roce beat");
        roce_first = roce_beat.last;
      end
      if (other_valid && other_ready)
      begin
        check_equal(1024'(exp_other.size() != 0), 1024'(1), "unexpected other beat");
        check_equal(1024'(other_beat), 1024'(exp_other.pop_front()), "other beat");
      end
    end
  end

  //====================================================================
  // Input side
  //====================================================================

  // Holds one beat on the input until in_ready takes it
  task automatic send_beat(input beat_t b);
    logic taken;
    taken    = 1'b0;
    in_beat  = b;
    in_valid = 1'b1;
    while (!taken)
    begin
      taken = in_ready;
      if (stall && in_ready)
      begin
        stall_accepts++;
      end
      else if (stall)
      begin
        check_equal(1024'(stall_accepts <= FIFO_DEPTH + 4), 1024'(1), "in_ready drop");
        stall      = 1'b0;
        stall_seen = 1'b1;
      end
      @(negedge axis_aclk);
    end
    in_valid = 1'b0;
  endtask

  task automatic send_packet(input int p);
    int          base;
    int          nb;
    int          bytes;
    logic        is_roce_exp;
    first_beat_u fb;
    beat_t       b;
    roce_meta_t  m;
    base = p * COLS;
    nb   = int'(td[base+8]);
    // IPv4, UDP and port 4791 together make a RoCE packet
    is_roce_exp = (td[base][15:0] == 16'h0800) && (td[base+1][7:0] == 8'h11) &&
                  (td[base+2][15:0] == 16'd4791);
    check_equal(1024'(is_roce_exp), 1024'(td[base+10][0]), $sformatf("route of packet %0d", p));
    for (int w = 0; w < 16; w++)
    begin
      fb.raw[w*32 +: 32] = $urandom;
    end
    fb.hdr.ethertype  = td[base][15:0];
    fb.hdr.ip_proto   = td[base+1][7:0];
    fb.hdr.udp_dport  = td[base+2][15:0];
    fb.hdr.udp_sport  = td[base+3][15:0];
    fb.hdr.ip_src     = td[base+4];
    fb.hdr.ip_dst     = td[base+5];
    fb.hdr.bth_opcode = td[base+6][7:0];
    fb.hdr.bth_psn    = td[base+7][23:0];
    if (is_roce_exp)
    begin
      m.ip_src    = td[base+4];
      m.ip_dst    = td[base+5];
      m.udp_sport = td[base+3][15:0];
      m.udp_dport = td[base+2][15:0];
      m.opcode    = td[base+6][4:0];
      m.psn       = td[base+7][23:0];
      m.pktlen    = td[base+9][15:0];
      m.is_rdma   = 1'b1;
      exp_meta.push_back(m);
      n_roce_pkts++;
    end
    else
    begin
      n_other_pkts++;
    end
    for (int k = 0; k < nb; k++)
    begin
      b.data = fb.raw;
      if (k != 0)
      begin
        for (int w = 0; w < 16; w++)
        begin
          b.data[w*32 +: 32] = $urandom;
        end
      end
      bytes  = int'(td[base+9][15:0]) - 64 * k;
      b.keep = (bytes >= 64) ? '1 : ((64'd1 << bytes) - 64'd1);
      b.size = td[base+9][15:0];
      b.last = (k == nb - 1);
      if (is_roce_exp)
      begin
        exp_roce.push_back(b);
      end
      else
      begin
        exp_other.push_back(b);
      end
      send_beat(b);
    end
  endtask

  initial
  begin
    void'($urandom(32'h0188ff37));
    for (int i = 0; i < MAX_PKTS * COLS; i++)
    begin
      td[i] = '0;
    end
    $readmemh("tests/roce_rx_testdata.hex", td);
    // A zero beat count ends the packet list
    while ((n_pkts < MAX_PKTS) && (td[n_pkts*COLS+8] != 32'd0))
    begin
      total_beats += int'(td[n_pkts*COLS+8]);
      n_pkts++;
    end
    check_equal(1024'(n_pkts > STALL_PKT), 1024'(1), "too few packets in test data");
    cycle_limit = 40 * total_beats + 200;

    repeat (8) @(negedge axis_aclk);
    axis_rstn = 1'b1;
    @(negedge axis_aclk);
    check_equal(1024'({roce_valid, other_valid, meta_valid}), 1024'(0), "valids after reset");
    check_equal(1024'({roce_count, other_count}), 1024'(0), "counts after reset");
    check_equal(1024'(in_ready), 1024'(1), "in_ready after reset");

    for (int p = 0; p < n_pkts; p++)
    begin
      if (p == STALL_PKT)
      begin
        stall_accepts = 0;
        stall         = 1'b1;
      end
      send_packet(p);
      repeat ($urandom % 3) @(negedge axis_aclk);
    end

    while ((exp_roce.size() != 0) || (exp_other.size() != 0) || roce_valid || other_valid)
    begin
      @(negedge axis_aclk);
    end
    repeat (2) @(negedge axis_aclk);
    check_equal(1024'(stall_seen), 1024'(1), "in_ready never dropped under back-pressure");
    check_equal(1024'(exp_meta.size()), 1024'(0), "metadata records left over");
    check_equal(1024'(roce_count), 1024'(n_roce_pkts), "roce_count");
    check_equal(1024'(other_count), 1024'(n_other_pkts), "other_count");
    $display("Everything OK");
    $finish;
  end

endmodule

//--- tests/roce_rx_testdata.hex
// ethertype ip_proto udp_dport udp_sport ip_src ip_dst opcode psn beats size route
// route 1 is the RoCE output, 0 the host output; size in bytes
0800 11 12b7 c001 0a000001 0a000002 0a 000100 1 003c 1
0800 11 12b7 c002 0a000003 0a000004 06 000200 2 0060 1
86dd 11 12b7 c003 0a000005 0a000006 04 000300 2 0080 0
0800 06 12b7 c004 0a000007 0a000008 04 000400 3 00b4 0
0800 11 12b6 c005 0a000009 0a00000a 04 000500 1 0040 0
0800 11 12b7 c006 c0a80001 c0a80002 64 abcdef 4 00f0 1
0806 06 0035 c007 c0a80003 c0a80004 00 000000 1 003c 0
0800 11 0035 e123 c0a80005 08080808 00 000000 2 0050 0
0800 11 12b7 c008 ac100001 ac100002 0a fffffe 3 00c0 1
0800 11 12b7 c009 ac100003 ac100004 11 ffffff 1 0040 1
0800 11 12b7 c00a ac100005 ac100006 04 000000 4 0100 1
86dd 06 12b7 c00b ac100007 ac100008 0a 123456 2 0070 0
0800 11 12b8 c00c ac100009 ac10000a 0a 234567 3 0090 0
0800 11 12b7 c00d 0a0a0a01 0a0a0a02 0c 345678 2 007e 1
0800 01 0000 0000 0a0a0a03 0a0a0a04 00 000000 1 003c 0
0800 11 12b7 c00e 0a0a0a05 0a0a0a06 1f 456789 4 00c8 1
8100 11 12b7 c00f 0a0a0a07 0a0a0a08 0a 56789a 2 0044 0
0800 11 12b7 c010 0a0a0a09 0a0a0a0a 0d 6789ab 2 0041 1

//--- vlog.f
hw/roce_proto_pkg.sv
hw/axis_stream_pkg.sv
hw/rx_fifo.sv
hw/header_parser.sv
hw/pkt_steer.sv
hw/pkt_counter.sv
hw/roce_rx_top.sv
tests/roce_rx_props.sv
tests/tb_roce_rx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_roce_rx
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
